//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// major opcodes handled by the decoder
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct7 for the base op and for SUB/SRA
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_e;

	// decode to execute
	typedef struct packed {
		alu_op_e alu_op;
		word_t operand_a;
		word_t operand_b;
		reg_addr_t rd;
		logic rd_wen;
	} issue_t;

	// finished instruction and bypass value
	typedef struct packed {
		reg_addr_t rd;
		word_t data;
		logic rd_wen;
	} commit_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
	input logic clock,
	input logic reset,
	input rv_pkg::reg_addr_t rs1_addr_i,
	input rv_pkg::reg_addr_t rs2_addr_i,
	output rv_pkg::word_t rs1_data_o,
	output rv_pkg::word_t rs2_data_o,
	input logic wr_en_i,
	input rv_pkg::commit_t wr_i
);

	// x0 has no storage
	rv_pkg::word_t regs [1:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_i.rd_wen && (wr_i.rd != '0)) begin
			regs[wr_i.rd] <= wr_i.data;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// decode never marks x0 as a destination
	a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
		(wr_en_i && wr_i.rd_wen) |-> (wr_i.rd != '0));

endmodule

`default_nettype wire

//--- rv_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode_stage (
	input logic clock,
	input logic reset,
	input logic inst_valid_i,
	output logic inst_ready_o,
	input rv_pkg::inst_t inst_i,
	output logic issue_valid_o,
	input logic issue_ready_i,
	output rv_pkg::issue_t issue_o,
	input rv_pkg::commit_t ex_fwd_i,
	input rv_pkg::commit_t wb_fwd_i,
	output rv_pkg::reg_addr_t rs1_addr_o,
	output rv_pkg::reg_addr_t rs2_addr_o,
	input rv_pkg::word_t rs1_data_i,
	input rv_pkg::word_t rs2_data_i
);

	rv_pkg::inst_t inst_q;
	logic full_q;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::reg_addr_t rd;
	rv_pkg::word_t imm_itype;
	rv_pkg::word_t imm_utype;
	rv_pkg::word_t rs1_val;
	rv_pkg::word_t rs2_val;
	rv_pkg::alu_op_e alu_op;
	logic use_imm;
	logic is_lui;
	logic legal;
	logic base;
	logic alt;

	// newest producer wins and x0 is never bypassed
	function automatic rv_pkg::word_t fwd_select(
		input rv_pkg::reg_addr_t addr,
		input rv_pkg::word_t rf_data,
		input rv_pkg::commit_t ex_fwd,
		input rv_pkg::commit_t wb_fwd
	);
		rv_pkg::word_t sel;
		sel = rf_data;
		if (addr != '0) begin
			if (ex_fwd.rd_wen && (ex_fwd.rd == addr)) begin
				sel = ex_fwd.data;
			end else if (wb_fwd.rd_wen && (wb_fwd.rd == addr)) begin
				sel = wb_fwd.data;
			end
		end
		return sel;
	endfunction

	assign inst_ready_o = !full_q || issue_ready_i;
	assign issue_valid_o = full_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			full_q <= 1'b0;
		end else if (inst_valid_i && inst_ready_o) begin
			full_q <= 1'b1;
		end else if (issue_ready_i) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid_i && inst_ready_o) begin
			inst_q <= inst_i;
		end
	end

	assign opcode = inst_q[6:0];
	assign rd = inst_q[11:7];
	assign funct3 = inst_q[14:12];
	assign funct7 = inst_q[31:25];
	assign rs1_addr_o = inst_q[19:15];
	assign rs2_addr_o = inst_q[24:20];
	assign imm_itype = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_utype = {inst_q[31:12], 12'b0};
	assign base = (funct7 == rv_pkg::F7_BASE);
	assign alt = (funct7 == rv_pkg::F7_ALT);
	assign is_lui = (opcode == rv_pkg::OPC_LUI);

	always_comb begin
		alu_op = rv_pkg::ALU_PASS_B;
		use_imm = 1'b0;
		legal = 1'b0;
		case (opcode)
			rv_pkg::OPC_OP: begin
				legal = base || (alt && (funct3 == rv_pkg::F3_ADD_SUB ||
					funct3 == rv_pkg::F3_SRL_SRA));
			end
			rv_pkg::OPC_OP_IMM: begin
				use_imm = 1'b1;
				// only shifts care about funct7 here
				if (funct3 == rv_pkg::F3_SLL) begin
					legal = base;
				end else if (funct3 == rv_pkg::F3_SRL_SRA) begin
					legal = base || alt;
				end else begin
					legal = 1'b1;
				end
			end
			rv_pkg::OPC_LUI: legal = 1'b1;
			default: legal = 1'b0;
		endcase
		if (!is_lui) begin
			case (funct3)
				rv_pkg::F3_ADD_SUB: begin
					alu_op = (alt && !use_imm) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
				end
				rv_pkg::F3_SLL: alu_op = rv_pkg::ALU_SLL;
				rv_pkg::F3_SLT: alu_op = rv_pkg::ALU_SLT;
				rv_pkg::F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
				rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
				rv_pkg::F3_SRL_SRA: alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
				rv_pkg::F3_OR: alu_op = rv_pkg::ALU_OR;
				default: alu_op = rv_pkg::ALU_AND;
			endcase
		end
	end

	assign rs1_val = fwd_select(rs1_addr_o, rs1_data_i, ex_fwd_i, wb_fwd_i);
	assign rs2_val = fwd_select(rs2_addr_o, rs2_data_i, ex_fwd_i, wb_fwd_i);

	// unknown encodings leave as a bubble
	always_comb begin
		issue_o.alu_op = legal ? alu_op : rv_pkg::ALU_PASS_B;
		issue_o.operand_a = rs1_val;
		if (!legal) begin
			issue_o.operand_b = '0;
		end else if (is_lui) begin
			issue_o.operand_b = imm_utype;
		end else if (use_imm) begin
			issue_o.operand_b = imm_itype;
		end else begin
			issue_o.operand_b = rs2_val;
		end
		issue_o.rd = legal ? rd : '0;
		issue_o.rd_wen = legal && (rd != '0);
	end

	// forwarded operands must not move while the issue register is stalled
	a_issue_stable: assert property (@(posedge clock) disable iff (reset)
		(issue_valid_o && !issue_ready_i) |=> $stable(issue_o));

endmodule

`default_nettype wire

//--- rv_issue_reg.sv
`timescale 1ns/100ps
`default_nettype none

module rv_issue_reg (
	input logic clock,
	input logic reset,
	input logic in_valid_i,
	output logic in_ready_o,
	input rv_pkg::issue_t in_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output rv_pkg::issue_t out_o
);

	logic valid_q;
	rv_pkg::issue_t data_q;

	// accept when empty or draining on this edge
	assign in_ready_o = !valid_q || out_ready_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (in_valid_i && in_ready_o) begin
			valid_q <= 1'b1;
		end else if (out_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_o = data_q;

endmodule

`default_nettype wire

//--- rv_execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute_stage (
	input logic clock,
	input logic reset,
	input logic issue_valid_i,
	output logic issue_ready_o,
	input rv_pkg::issue_t issue_i,
	output logic commit_valid_o,
	input logic commit_ready_i,
	output rv_pkg::commit_t commit_o,
	output logic commit_fire_o,
	output rv_pkg::commit_t ex_fwd_o
);

	logic valid_q;
	rv_pkg::commit_t commit_q;
	rv_pkg::word_t result;
	rv_pkg::word_t op_a;
	rv_pkg::word_t op_b;
	logic [4:0] shamt;
	logic accept;

	assign op_a = issue_i.operand_a;
	assign op_b = issue_i.operand_b;
	assign shamt = op_b[4:0];

	always_comb begin
		case (issue_i.alu_op)
			rv_pkg::ALU_ADD: result = op_a + op_b;
			rv_pkg::ALU_SUB: result = op_a - op_b;
			rv_pkg::ALU_AND: result = op_a & op_b;
			rv_pkg::ALU_OR: result = op_a | op_b;
			rv_pkg::ALU_XOR: result = op_a ^ op_b;
			rv_pkg::ALU_SLL: result = op_a << shamt;
			rv_pkg::ALU_SRL: result = op_a >> shamt;
			rv_pkg::ALU_SRA: result = rv_pkg::word_t'($signed(op_a) >>> shamt);
			rv_pkg::ALU_SLT: begin
				result = {{(rv_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			end
			rv_pkg::ALU_SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, (op_a < op_b)};
			default: result = op_b;
		endcase
	end

	// pending slot empty or handing off this edge
	assign issue_ready_o = !valid_q || commit_ready_i;
	assign accept = issue_valid_i && issue_ready_o;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
		end else if (commit_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			commit_q.rd <= issue_i.rd;
			commit_q.data <= result;
			commit_q.rd_wen <= issue_i.rd_wen;
		end
	end

	assign commit_valid_o = valid_q;
	assign commit_o = commit_q;
	assign commit_fire_o = valid_q && commit_ready_i;

	// bypass of the instruction currently in the ALU
	assign ex_fwd_o.rd = issue_i.rd;
	assign ex_fwd_o.data = result;
	assign ex_fwd_o.rd_wen = issue_i.rd_wen && issue_valid_i;

	a_commit_hold: assert property (@(posedge clock) disable iff (reset)
		(commit_valid_o && !commit_ready_i) |=> (commit_valid_o && $stable(commit_o)));

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
	input logic clock,
	input logic reset,
	input logic inst_valid_i,
	output logic inst_ready_o,
	input rv_pkg::inst_t inst_i,
	output logic commit_valid_o,
	input logic commit_ready_i,
	output rv_pkg::commit_t commit_o
);

	logic dec_valid;
	logic dec_ready;
	rv_pkg::issue_t dec_issue;
	logic ex_valid;
	logic ex_ready;
	rv_pkg::issue_t ex_issue;
	rv_pkg::commit_t ex_fwd;
	rv_pkg::commit_t wb_fwd;
	logic commit_fire;
	rv_pkg::reg_addr_t rs1_addr;
	rv_pkg::reg_addr_t rs2_addr;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;

	// held commit only forwards while it is valid
	assign wb_fwd = {commit_o.rd, commit_o.data, commit_o.rd_wen & commit_valid_o};

	rv_decode_stage decode0 (
		.clock(clock),
		.reset(reset),
		.inst_valid_i(inst_valid_i),
		.inst_ready_o(inst_ready_o),
		.inst_i(inst_i),
		.issue_valid_o(dec_valid),
		.issue_ready_i(dec_ready),
		.issue_o(dec_issue),
		.ex_fwd_i(ex_fwd),
		.wb_fwd_i(wb_fwd),
		.rs1_addr_o(rs1_addr),
		.rs2_addr_o(rs2_addr),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data)
	);

	rv_issue_reg issue0 (
		.clock(clock),
		.reset(reset),
		.in_valid_i(dec_valid),
		.in_ready_o(dec_ready),
		.in_i(dec_issue),
		.out_valid_o(ex_valid),
		.out_ready_i(ex_ready),
		.out_o(ex_issue)
	);

	rv_execute_stage execute0 (
		.clock(clock),
		.reset(reset),
		.issue_valid_i(ex_valid),
		.issue_ready_o(ex_ready),
		.issue_i(ex_issue),
		.commit_valid_o(commit_valid_o),
		.commit_ready_i(commit_ready_i),
		.commit_o(commit_o),
		.commit_fire_o(commit_fire),
		.ex_fwd_o(ex_fwd)
	);

	rv_regfile regfile0 (
		.clock(clock),
		.reset(reset),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data),
		.wr_en_i(commit_fire),
		.wr_i(commit_o)
	);

endmodule

`default_nettype wire

//--- rv_commit_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_commit_checker (
	input logic clock,
	input logic reset,
	input logic commit_valid_i,
	input logic commit_ready_i,
	input rv_pkg::commit_t commit_i,
	output int error_count_o,
	output int checked_count_o
);

	// expected commits in program order
	string name_q[$];
	rv_pkg::reg_addr_t rd_q[$];
	rv_pkg::word_t data_q[$];
	int errors;
	int checked;

	initial begin
		errors = 0;
		checked = 0;
	end

	assign error_count_o = errors;
	assign checked_count_o = checked;

	task automatic add_expected(input string name, input rv_pkg::reg_addr_t rd,
		input rv_pkg::word_t data);
		name_q.push_back(name);
		rd_q.push_back(rd);
		data_q.push_back(data);
	endtask

	// handshake settles mid-cycle and transfers on the next rising edge
	always @(negedge clock) begin : check_commit
		string name;
		string exp_str;
		string act_str;
		rv_pkg::reg_addr_t exp_rd;
		rv_pkg::word_t exp_data;
		logic exp_wen;
		if (!reset && commit_valid_i && commit_ready_i) begin
			if (name_q.size() == 0) begin
				$display("unexpected commit to x%0d with data %h and nothing outstanding",
					commit_i.rd, commit_i.data);
				errors++;
			end else begin
				name = name_q.pop_front();
				exp_rd = rd_q.pop_front();
				exp_data = data_q.pop_front();
				// bubbles and x0 writes never enable the write
				exp_wen = (exp_rd != '0);
				checked++;
				if (commit_i.rd !== exp_rd || commit_i.data !== exp_data ||
					commit_i.rd_wen !== exp_wen) begin
					exp_str = $sformatf("rd %0d data %h rd_wen %b",
						exp_rd, exp_data, exp_wen);
					act_str = $sformatf("rd %0d data %h rd_wen %b",
						commit_i.rd, commit_i.data, commit_i.rd_wen);
					$display("Fail %s: expected %s, actual %s", name, exp_str, act_str);
					errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

	logic clock;
	logic reset;
	logic inst_valid_i;
	logic inst_ready_o;
	rv_pkg::inst_t inst_i;
	logic commit_valid_o;
	logic commit_ready_i;
	rv_pkg::commit_t commit_o;

	string case_name[$];
	rv_pkg::inst_t case_inst[$];
	rv_pkg::reg_addr_t case_rd[$];
	rv_pkg::word_t case_data[$];
	int checker_errors;
	int checked;
	int tb_errors;
	int limit;
	integer seed;
	logic timed_out;

	rv_core dut0 (
		.clock(clock),
		.reset(reset),
		.inst_valid_i(inst_valid_i),
		.inst_ready_o(inst_ready_o),
		.inst_i(inst_i),
		.commit_valid_o(commit_valid_o),
		.commit_ready_i(commit_ready_i),
		.commit_o(commit_o)
	);

	rv_commit_checker checker0 (
		.clock(clock),
		.reset(reset),
		.commit_valid_i(commit_valid_o),
		.commit_ready_i(commit_ready_i),
		.commit_i(commit_o),
		.error_count_o(checker_errors),
		.checked_count_o(checked)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// random commit back-pressure on roughly one cycle in four
	initial begin
		seed = 32'he439;
		commit_ready_i = 1'b1;
		forever begin
			@(posedge clock);
			#1;
			commit_ready_i = (($random(seed) & 3) != 0);
		end
	end

	task automatic load_cases();
		integer fd;
		integer n;
		string name;
		string rest;
		logic [31:0] inst;
		logic [31:0] rd;
		logic [31:0] data;
		fd = $fopen("rv_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open rv_cases.txt");
			tb_errors++;
		end else begin
			n = $fscanf(fd, "%s", name);
			while (n == 1) begin
				if (name[0] == "#") begin
					n = $fgets(rest, fd);
				end else if ($fscanf(fd, "%h %h %h", inst, rd, data) == 3) begin
					case_name.push_back(name);
					case_inst.push_back(inst);
					case_rd.push_back(rd[4:0]);
					case_data.push_back(data);
				end else begin
					$display("malformed line in rv_cases.txt after %s", name);
					tb_errors++;
				end
				n = $fscanf(fd, "%s", name);
			end
			$fclose(fd);
		end
		if (case_inst.size() == 0) begin
			$display("no test cases were loaded");
			tb_errors++;
		end
	endtask

	// starts just after a rising edge and returns just after the transfer edge
	task automatic send_instruction(input rv_pkg::inst_t inst);
		inst_valid_i = 1'b1;
		inst_i = inst;
		@(negedge clock);
		while (!inst_ready_o) begin
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		inst_valid_i = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		tb_errors = 0;
		timed_out = 1'b0;
		load_cases();
		limit = case_inst.size() * 20 + 50;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		if (inst_ready_o !== 1'b1 || commit_valid_o !== 1'b0) begin
			$display("after reset the core is not ready or already offers a commit");
			tb_errors++;
		end
		@(posedge clock);
		#1;
		fork
			begin
				for (int i = 0; i < case_inst.size(); i++) begin
					checker0.add_expected(case_name[i], case_rd[i], case_data[i]);
					send_instruction(case_inst[i]);
					// idle gap now and then
					if (i % 5 == 4) begin
						@(posedge clock);
						#1;
					end
				end
				wait (checked == case_inst.size());
			end
			begin
				repeat (limit) @(posedge clock);
				timed_out = 1'b1;
			end
		join_any
		disable fork;
		// catch any stray commit after the last one
		repeat (8) @(posedge clock);
		if (timed_out) begin
			$display("run timed out with %0d of %0d commits missing",
				case_inst.size() - checked, case_inst.size());
		end
		$display("errors: %0d in commits, %0d in testbench", checker_errors, tb_errors);
		if (!timed_out && checker_errors == 0 && tb_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_cases.txt
# columns: test name, instruction word (hex), expected rd (hex), expected data (hex)
# bubbles and writes to x0 expect rd 00
lui_x1          123450b7 01 12345000
addi_fwd_x1     67808093 01 12345678
addi_neg_x2     fff00113 02 ffffffff
add_x3          002081b3 03 12345677
sub_wrap_x4     40100233 04 edcba988
xor_x5          0040c2b3 05 fffffff0
and_x6          0050f333 06 12345670
or_x7           006263b3 07 fffffff8
slt_neg_x8      00122433 08 00000001
sltu_neg_x9     001234b3 09 00000000
slti_neg_x10    00122513 0a 00000001
sltiu_m1_x11    fff0b593 0b 00000001
slti_m1_x12     fff0a613 0c 00000000
srai_x13        40425693 0d fedcba98
srli_x14        00425713 0e 0edcba98
slli_x15        00809793 0f 34567800
addi_shamt_x16  02400813 10 00000024
sra_reg_x17     410258b3 11 fedcba98
srl_reg_x18     01025933 12 0edcba98
sll_reg_x19     010119b3 13 fffffff0
andi_neg_x20    ff00fa13 14 12345670
ori_x21         7ff06a93 15 000007ff
xori_not_x22    fff0cb13 16 edcba987
chain_x23       00100b93 17 00000001
chain_x24       017b8c33 18 00000002
chain_x25       017c0cb3 19 00000003
write_x0        010c8013 00 00000013
read_x0_x26     01900d33 1a 00000003
bubble_branch   12345463 00 00000000
addi_x27        ffbd0d93 1b fffffffe
bubble_mul      02108e33 00 00000000
sub_x29         402d8eb3 1d ffffffff

//--- sim.f
rv_pkg.sv
rv_regfile.sv
rv_decode_stage.sv
rv_issue_reg.sv
rv_execute_stage.sv
rv_core.sv
rv_commit_checker.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_regfile.sv
  - rv_decode_stage.sv
  - rv_issue_reg.sv
  - rv_execute_stage.sv
  - rv_core.sv
  - target: simulation
    files:
      - rv_commit_checker.sv
      - tb_rv_core.sv
